/* capture_pkg.sv */
`default_nettype none

package capture_pkg;

    ////////////////////////////////////////
    // converter and memory word geometry
    ////////////////////////////////////////
    localparam int ADC_WIDTH  = 14;                 // one converter code
    localparam int HALF_WIDTH = 16;                 // one channel field in a word
    localparam int WORD_WIDTH = 2 * HALF_WIDTH;     // chan b high, chan a low

    // window shape
    localparam int PRE_SAMPLES      = 4;            // history kept ahead of the trigger
    localparam int POST_SAMPLES     = 28;           // trigger sample counts here
    localparam int WINDOW_WORDS     = PRE_SAMPLES + POST_SAMPLES;
    localparam int NUM_WINDOWS      = 10;           // ring slots
    localparam int SLOT_WIDTH       = $clog2(NUM_WINDOWS);
    localparam int WORD_INDEX_WIDTH = $clog2(WINDOW_WORDS);

    ////////////////////////////////////////
    // timebase
    ////////////////////////////////////////
    localparam int TIME_WIDTH  = 26;
    localparam int TIME_WRAP   = 49_999_999;        // one second of 50 MHz ticks
    localparam int PULSE_WIDTH = 32;

    // trigger threshold
    // codes at or above NEG_BOUND are negative readings
    localparam int NEG_BOUND     = 8192;
    localparam int CODE_SPAN     = 16384;           // 2**ADC_WIDTH
    localparam int TRIGGER_DEPTH = 5400;            // magnitude must exceed this

    typedef logic [ADC_WIDTH-1:0]   adc_code_t;
    typedef logic [TIME_WIDTH-1:0]  time_t;
    typedef logic [PULSE_WIDTH-1:0] pulse_num_t;

    // one stored word, seen raw by the ring and as two channels by capture
    typedef union packed {
        logic [WORD_WIDTH-1:0] raw;
        struct packed {
            logic [HALF_WIDTH-1:0] b;               // high half
            logic [HALF_WIDTH-1:0] a;               // low half
        } ch;
    } sample_word_u;

endpackage

`default_nettype wire

/* pps_timebase.sv */
`timescale 1ns/1ns
`default_nettype none

module pps_timebase (
    input  wire                     ADA_DCO,
    input  wire                     hps_fpga_reset_n,
    input  wire                     pps,
    output capture_pkg::time_t      timestamp,
    output capture_pkg::pulse_num_t pps_count,
    output capture_pkg::time_t      pps_time
);
    import capture_pkg::*;

    logic pps_s1;     // first sync flop
    logic pps_s2;     // second sync flop
    logic pps_s3;     // previous synced level
    logic pps_rise;

    ////////////////////////////////////////
    // free-running timestamp
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            timestamp <= '0;
        end
        else if (timestamp == TIME_WIDTH'(TIME_WRAP))
        begin
            timestamp <= '0;                      // wrap once per second
        end
        else
        begin
            timestamp <= timestamp + 1'b1;
        end
    end

    ////////////////////////////////////////
    // pps sync and edge
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            pps_s1 <= 1'b0;
            pps_s2 <= 1'b0;
            pps_s3 <= 1'b0;
        end
        else
        begin
            pps_s1 <= pps;                        // async input
            pps_s2 <= pps_s1;
            pps_s3 <= pps_s2;
        end
    end

    assign pps_rise = pps_s2 & ~pps_s3;

    // count and stamp, third edge after pps goes high
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            pps_count <= '0;
            pps_time  <= '0;
        end
        else if (pps_rise)
        begin
            pps_count <= pps_count + 1'b1;
            pps_time  <= timestamp;
        end
    end

    timestamp_in_range: assert property (@(posedge ADA_DCO) disable iff (~hps_fpga_reset_n)
        timestamp <= TIME_WIDTH'(TIME_WRAP));

endmodule

`default_nettype wire

/* pulse_capture_top.f */
capture_pkg.sv
window_if.sv
pps_timebase.sv
window_capture.sv
window_ring.sv
pulse_capture_top.sv
tb_pulse_capture.sv

/* pulse_capture_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pulse_capture_top (
    input  wire                                 ADA_DCO,
    input  wire                                 hps_fpga_reset_n,
    input  wire capture_pkg::adc_code_t         ada_d,
    input  wire capture_pkg::adc_code_t         adb_d,
    input  wire                                 pps,
    input  wire                                 read_req,       // single-cycle strobe
    output wire                                 rd_valid,
    output wire [capture_pkg::WORD_WIDTH-1:0]   rd_word,
    output wire capture_pkg::time_t             rd_time,
    output wire capture_pkg::pulse_num_t        rd_pulse_num,
    output wire [capture_pkg::SLOT_WIDTH-1:0]   rd_slot,
    output wire capture_pkg::pulse_num_t        pps_count,
    output wire capture_pkg::time_t             pps_time
);
    import capture_pkg::*;

    wire time_t timestamp;                      // shared time of day

    window_if win ();                           // capture to ring

    ////////////////////////////////////////
    // timebase
    ////////////////////////////////////////
    pps_timebase i_pps_timebase (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .pps              (pps),
        .timestamp        (timestamp),
        .pps_count        (pps_count),
        .pps_time         (pps_time)
    );

    // trigger and window stream
    window_capture i_window_capture (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .timestamp        (timestamp),
        .win              (win.source)
    );

    // window storage and host readout
    window_ring i_window_ring (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .win              (win.sink),
        .read_req         (read_req),
        .rd_valid         (rd_valid),
        .rd_word          (rd_word),
        .rd_time          (rd_time),
        .rd_pulse_num     (rd_pulse_num),
        .rd_slot          (rd_slot)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pulse_capture \
    -f pulse_capture_top.f

sim_out=$(./obj_dir/Vtb_pulse_capture)
echo "$sim_out"

if echo "$sim_out" | grep -qx "SIMULATION PASSED"
then
    exit 0
fi
exit 1

/* tb_pulse_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pulse_capture;
    import capture_pkg::*;

    localparam int GAP            = 40;                 // quiet cycles after a window
    localparam int PLAN_CYCLES    = 1250;               // rough length of the main sequence
    localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES + 200;

    logic                  ADA_DCO;
    logic                  hps_fpga_reset_n;
    adc_code_t             ada_d;
    adc_code_t             adb_d;
    logic                  pps;
    logic                  read_req;
    logic                  rd_valid;
    logic [WORD_WIDTH-1:0] rd_word;
    time_t                 rd_time;
    pulse_num_t            rd_pulse_num;
    logic [SLOT_WIDTH-1:0] rd_slot;
    pulse_num_t            pps_count;
    time_t                 pps_time;

    integer      seed;
    int          cyc;                                   // posedges since time 0
    int          value_errors;
    int          other_errors;
    logic [31:0] hist [0:4095];                         // packed pair driven per cycle
    int          trig_q [$];                            // trigger cycle per expected window
    int          pnum_q [$];
    int          next_arm;                              // first cycle a trigger may land
    int          fill_m;                                // windows held, model view
    int          pulses_m;
    bit          read_pending;
    int          req_cyc;
    int          bursts_done;
    bit          pps_done;
    int          pps_gaps [5] = '{97, 151, 230, 64, 311};
    int          edge_cyc;
    time_t       pps_base;

    // burst monitor state
    int                    beat;
    int                    cur_trig;
    int                    cur_pnum;
    bit                    prev_valid;
    bit                    have_base;
    time_t                 time_base;
    time_t                 hold_time;
    pulse_num_t            hold_pnum;
    logic [SLOT_WIDTH-1:0] hold_slot;

    pulse_capture_top i_pulse_capture_top (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .pps              (pps),
        .read_req         (read_req),
        .rd_valid         (rd_valid),
        .rd_word          (rd_word),
        .rd_time          (rd_time),
        .rd_pulse_num     (rd_pulse_num),
        .rd_slot          (rd_slot),
        .pps_count        (pps_count),
        .pps_time         (pps_time)
    );

    always #50 ADA_DCO = ~ADA_DCO;                     // 100 ns period

    always @(posedge ADA_DCO) cyc <= cyc + 1;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    // negative reading deeper than the threshold
    function automatic bit is_trigger_code(input adc_code_t code);
        int c;
        c = int'(code);
        return (c >= NEG_BOUND) && ((CODE_SPAN - c) > TRIGGER_DEPTH);
    endfunction

    // word j of a window = sample PRE_SAMPLES before the trigger plus j
    function automatic logic [31:0] expected_word(input int trig, input int j);
        int idx;
        idx = trig - PRE_SAMPLES + j;
        if (idx < 0)
        begin
            return '0;                                  // nothing driven yet
        end
        return hist[idx];
    endfunction

    function automatic adc_code_t background_code();
        logic [31:0] rnd;
        adc_code_t   code;
        rnd  = $random(seed);
        code = rnd[ADC_WIDTH-1:0];
        if (is_trigger_code(code))
        begin
            code[ADC_WIDTH-1] = 1'b0;                   // fold to a positive reading
        end
        return code;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////
    // one sample pair and an optional read strobe per falling edge
    task automatic step(input adc_code_t a, input bit req);
        logic [31:0] rnd;
        adc_code_t   b;
        @(negedge ADA_DCO);
        rnd      = $random(seed);
        b        = rnd[ADC_WIDTH-1:0];
        ada_d    = a;
        adb_d    = b;
        read_req = req;
        hist[cyc] = {2'b00, b, 2'b00, a};               // b in the high half
        if (is_trigger_code(a) && cyc >= next_arm && fill_m < NUM_WINDOWS)
        begin
            pulses_m++;
            trig_q.push_back(cyc);
            pnum_q.push_back(pulses_m);
            next_arm = cyc + WINDOW_WORDS + 1;          // rearms after word 31
            fill_m++;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step(background_code(), 1'b0);
    endtask

    // read the oldest window and optionally poke read_req again mid burst
    task automatic read_window(input bit extra_req);
        int target;
        int waited;
        target = bursts_done + 1;
        step(background_code(), 1'b1);
        req_cyc      = cyc;
        read_pending = 1'b1;
        fill_m--;
        waited = 0;
        while (bursts_done < target)
        begin
            if (extra_req && waited == 12)
            begin
                step(background_code(), 1'b1);          // must be ignored
            end
            else
            begin
                idle(1);
            end
            waited++;
        end
        idle(2);
    endtask

    task automatic read_empty();
        step(background_code(), 1'b1);                  // monitor flags any burst
        idle(6);
    endtask

    ////////////////////////////////////////
    // burst monitor
    ////////////////////////////////////////
    always @(negedge ADA_DCO)
    begin
        if (hps_fpga_reset_n)
        begin
            if (rd_valid && !prev_valid)
            begin
                if (!read_pending)
                begin
                    other_errors++;
                    $display("%0t ns: rd_valid rose with no accepted read request", $time);
                end
                else
                begin
                    check_value("rd_valid latency", 2, cyc - req_cyc);
                end
                read_pending = 1'b0;
                if (trig_q.size() == 0)
                begin
                    other_errors++;
                    $display("%0t ns: burst came out with no window expected", $time);
                    cur_trig = 0;
                    cur_pnum = 0;
                end
                else
                begin
                    cur_trig = trig_q.pop_front();
                    cur_pnum = pnum_q.pop_front();
                end
                if (!have_base)
                begin
                    time_base = rd_time - time_t'(cur_trig);   // offset of the counter
                    have_base = 1'b1;
                end
                beat      = 0;
                hold_time = rd_time;
                hold_pnum = rd_pulse_num;
                hold_slot = rd_slot;
                check_value("rd_pulse_num", cur_pnum, rd_pulse_num);
                check_value("rd_slot", (cur_pnum - 1) % NUM_WINDOWS, 32'(rd_slot));
                check_value("rd_time", 32'(time_t'(time_base + time_t'(cur_trig))),
                            32'(rd_time));
            end
            if (rd_valid)
            begin
                check_value("rd_word", expected_word(cur_trig, beat), rd_word);
                check_value("rd_time hold", 32'(hold_time), 32'(rd_time));
                check_value("rd_pulse_num hold", hold_pnum, rd_pulse_num);
                check_value("rd_slot hold", 32'(hold_slot), 32'(rd_slot));
                beat++;
            end
            else if (prev_valid)
            begin
                check_value("burst length", WINDOW_WORDS, beat);
                bursts_done++;
            end
            prev_valid = rd_valid;
        end
    end

    always @(posedge ADA_DCO)
    begin
        if (cyc == TIMEOUT_CYCLES)
        begin
            other_errors++;
            $display("%0t ns: run timed out after %0d cycles", $time, cyc);
            finish_run();
        end
    end

    ////////////////////////////////////////
    // pps edges in their own process
    ////////////////////////////////////////
    initial
    begin
        wait (hps_fpga_reset_n);
        for (int k = 0; k < 5; k++)
        begin
            repeat (pps_gaps[k]) @(negedge ADA_DCO);
            pps      = 1'b1;
            edge_cyc = cyc;
            repeat (3) @(negedge ADA_DCO);
            pps = 1'b0;
            @(negedge ADA_DCO);                         // count settled by now
            check_value("pps_count", k + 1, pps_count);
            if (k == 0)
            begin
                pps_base = pps_time - time_t'(edge_cyc);
            end
            else
            begin
                check_value("pps_time", 32'(time_t'(pps_base + time_t'(edge_cyc))),
                            32'(pps_time));
            end
        end
        pps_done = 1'b1;
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        seed             = 89544;
        ADA_DCO          = 1'b0;
        hps_fpga_reset_n = 1'b0;
        ada_d            = '0;
        adb_d            = '0;
        pps              = 1'b0;
        read_req         = 1'b0;
        cyc              = 0;
        value_errors     = 0;
        other_errors     = 0;
        next_arm         = 0;
        fill_m           = 0;
        pulses_m         = 0;
        read_pending     = 1'b0;
        bursts_done      = 0;
        pps_done         = 1'b0;
        for (int i = 0; i < 4096; i++)
        begin
            hist[i] = '0;
        end
        repeat (5) @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;

        // first window reaches back into reset so its early words are zero
        idle(1);
        step(adc_code_t'(CODE_SPAN - TRIGGER_DEPTH - 1), 1'b0);    // magnitude 5401
        idle(10);
        step(adc_code_t'(9000), 1'b0);                  // lands in the open window
        idle(GAP);

        // threshold edge and positive codes
        step(adc_code_t'(CODE_SPAN - TRIGGER_DEPTH), 1'b0);        // magnitude 5400
        idle(3);
        step(adc_code_t'(NEG_BOUND - 1), 1'b0);
        idle(3);
        step(adc_code_t'(0), 1'b0);
        idle(3);
        step(adc_code_t'(CODE_SPAN - 1), 1'b0);         // shallow negative
        idle(3);
        step(adc_code_t'(NEG_BOUND), 1'b0);             // deepest code
        idle(GAP);

        read_window(1'b1);                              // second strobe mid burst
        read_window(1'b0);
        read_empty();

        // read one window while the next is being written
        step(adc_code_t'(9500), 1'b0);
        idle(GAP);
        step(adc_code_t'(8800), 1'b0);
        idle(5);
        read_window(1'b0);
        idle(GAP);
        read_window(1'b0);

        // overfill so the last two triggers hit a full ring
        for (int i = 0; i < 12; i++)
        begin
            step(adc_code_t'(NEG_BOUND + 200 * i), 1'b0);
            idle(GAP);
        end
        repeat (NUM_WINDOWS) read_window(1'b0);
        read_empty();

        while (!pps_done)
        begin
            idle(1);
        end
        idle(4);
        check_value("windows read", pulses_m, bursts_done);
        finish_run();
    end

endmodule

`default_nettype wire

/* window_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module window_capture (
    input  wire                         ADA_DCO,
    input  wire                         hps_fpga_reset_n,
    input  wire capture_pkg::adc_code_t ada_d,
    input  wire capture_pkg::adc_code_t adb_d,
    input  wire capture_pkg::time_t     timestamp,
    window_if.source                    win
);
    import capture_pkg::*;

    adc_code_t          a_reg;                      // registered channel a
    adc_code_t          b_reg;                      // registered channel b
    sample_word_u       cur_word;
    sample_word_u       delay_line [PRE_SAMPLES];
    logic [ADC_WIDTH:0] neg_mag;                    // magnitude of a negative code
    logic               is_deep;
    logic               armed;
    logic               trigger;
    logic               last_word;

    ////////////////////////////////////////
    // input registers and packing
    ////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            a_reg <= '0;
            b_reg <= '0;
        end
        else
        begin
            a_reg <= ada_d;
            b_reg <= adb_d;
        end
    end

    // zero-extend each code into its half
    always_comb
    begin
        cur_word.ch.a = {{(HALF_WIDTH-ADC_WIDTH){1'b0}}, a_reg};
        cur_word.ch.b = {{(HALF_WIDTH-ADC_WIDTH){1'b0}}, b_reg};
    end

    // pre-trigger history
    // slot 0 holds the previous sample, the last slot the oldest
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            for (int i = 0; i < PRE_SAMPLES; i++)
            begin
                delay_line[i] <= '0;
            end
        end
        else
        begin
            delay_line[0] <= cur_word;
            for (int i = 1; i < PRE_SAMPLES; i++)
            begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // trigger decision
    ////////////////////////////////////////
    assign neg_mag = (ADC_WIDTH+1)'(CODE_SPAN) - {1'b0, a_reg};

    assign is_deep = (a_reg >= ADC_WIDTH'(NEG_BOUND))
                  && (neg_mag > (ADC_WIDTH+1)'(TRIGGER_DEPTH));

    assign last_word = win.word_valid
                    && (win.word_index == WORD_INDEX_WIDTH'(WINDOW_WORDS - 1));

    assign trigger = armed && ~win.ring_full && is_deep;   // ring_full checked live

    // window sequencing
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            armed             <= 1'b0;
            win.word_valid    <= 1'b0;
            win.word_index    <= '0;
            win.win_pulse_num <= '0;
        end
        else
        begin
            // rearm once the last word goes out and the ring has room
            armed <= ~trigger & ~win.ring_full & (~win.word_valid | last_word);

            if (trigger)
            begin
                win.word_valid    <= 1'b1;
                win.word_index    <= '0;
                win.win_pulse_num <= win.win_pulse_num + 1'b1;  // first pulse is 1
            end
            else if (win.word_valid)
            begin
                win.word_valid <= ~last_word;
                win.word_index <= win.word_index + 1'b1;       // wraps to 0 after 31
            end
        end
    end

    // word j leaves as the sample from trigger minus PRE_SAMPLES plus j
    always_ff @(posedge ADA_DCO)
    begin
        win.word <= delay_line[PRE_SAMPLES-1];
        if (trigger)
        begin
            win.win_time <= timestamp;            // time of the trigger sample
        end
    end

    // words of one window come on consecutive cycles
    window_words_in_order: assert property (@(posedge ADA_DCO) disable iff (~hps_fpga_reset_n)
        win.word_valid |-> (win.word_index < WINDOW_WORDS)
                           && (win.word_index == '0 || $past(win.word_valid)));

endmodule

`default_nettype wire

/* window_if.sv */
`timescale 1ns/1ns
`default_nettype none

// capture stage to ring, one word per cycle with no stall
interface window_if;
    import capture_pkg::*;

    logic                        word_valid;      // single-cycle strobe per word
    logic [WORD_INDEX_WIDTH-1:0] word_index;      // 0 .. 31 back to back
    sample_word_u                word;
    time_t                       win_time;        // stable for the whole window
    pulse_num_t                  win_pulse_num;   // stable for the whole window
    logic                        ring_full;       // holds off new triggers

    modport source (
        output word_valid,
        output word_index,
        output word,
        output win_time,
        output win_pulse_num,
        input  ring_full
    );

    modport sink (
        input  word_valid,
        input  word_index,
        input  word,
        input  win_time,
        input  win_pulse_num,
        output ring_full
    );

endinterface

`default_nettype wire

/* window_ring.sv */
`timescale 1ns/1ns
`default_nettype none

module window_ring (
    input  wire                                 ADA_DCO,
    input  wire                                 hps_fpga_reset_n,
    window_if.sink                              win,
    input  wire                                 read_req,
    output logic                                rd_valid,
    output logic [capture_pkg::WORD_WIDTH-1:0]  rd_word,
    output capture_pkg::time_t                  rd_time,
    output capture_pkg::pulse_num_t             rd_pulse_num,
    output logic [capture_pkg::SLOT_WIDTH-1:0]  rd_slot
);
    import capture_pkg::*;

    logic [WORD_WIDTH-1:0]       mem [NUM_WINDOWS*WINDOW_WORDS];
    time_t                       hdr_time  [NUM_WINDOWS];    // trigger time per slot
    pulse_num_t                  hdr_pulse [NUM_WINDOWS];    // pulse number per slot

    logic [SLOT_WIDTH-1:0]       wr_ptr;
    logic [SLOT_WIDTH-1:0]       rd_ptr;                     // oldest full slot
    logic [SLOT_WIDTH:0]         fill_count;
    logic                        commit;
    logic                        rd_busy;
    logic [WORD_INDEX_WIDTH-1:0] rd_index;
    logic                        rd_start;
    logic                        rd_done;

    function automatic logic [SLOT_WIDTH-1:0] next_slot(input logic [SLOT_WIDTH-1:0] slot);
        if (slot == SLOT_WIDTH'(NUM_WINDOWS - 1))
        begin
            return '0;
        end
        return slot + 1'b1;
    endfunction

    ////////////////////////////////////////
    // write side
    ////////////////////////////////////////
    assign commit        = win.word_valid
                        && (win.word_index == WORD_INDEX_WIDTH'(WINDOW_WORDS - 1));
    assign win.ring_full = (fill_count == (SLOT_WIDTH+1)'(NUM_WINDOWS));

    // {slot, index} is slot * WINDOW_WORDS + index
    always_ff @(posedge ADA_DCO)
    begin
        if (win.word_valid)
        begin
            mem[{wr_ptr, win.word_index}] <= win.word.raw;
        end
        if (commit)
        begin
            hdr_time[wr_ptr]  <= win.win_time;
            hdr_pulse[wr_ptr] <= win.win_pulse_num;
        end
        rd_word <= mem[{rd_slot, rd_index}];        // one-cycle read
        if (rd_start)
        begin
            rd_time      <= hdr_time[rd_ptr];       // held for the burst
            rd_pulse_num <= hdr_pulse[rd_ptr];
        end
    end

    // pointers and fill count
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            wr_ptr     <= '0;
            fill_count <= '0;
        end
        else
        begin
            if (commit)
            begin
                wr_ptr <= next_slot(wr_ptr);
            end
            case ({commit, rd_done})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;  // none or both
            endcase
        end
    end

    ////////////////////////////////////////
    // readout sequencer
    ////////////////////////////////////////
    assign rd_start = read_req && ~rd_busy && ~rd_valid && (fill_count != '0);
    assign rd_done  = rd_busy && (rd_index == WORD_INDEX_WIDTH'(WINDOW_WORDS - 1));

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (~hps_fpga_reset_n)
        begin
            rd_busy  <= 1'b0;
            rd_index <= '0;
            rd_slot  <= '0;
            rd_ptr   <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_busy;                    // lines up with registered read
            if (rd_start)
            begin
                rd_busy  <= 1'b1;
                rd_index <= '0;
                rd_slot  <= rd_ptr;
            end
            else if (rd_busy)
            begin
                rd_index <= rd_index + 1'b1;
                if (rd_done)
                begin
                    rd_busy <= 1'b0;
                    rd_ptr  <= next_slot(rd_ptr);   // slot freed
                end
            end
        end
    end

    // capture never delivers a window into a full ring
    fill_bounded: assert property (@(posedge ADA_DCO) disable iff (~hps_fpga_reset_n)
        (fill_count <= (SLOT_WIDTH+1)'(NUM_WINDOWS)) && ~(commit && win.ring_full));

    no_read_from_empty: assert property (@(posedge ADA_DCO) disable iff (~hps_fpga_reset_n)
        $rose(rd_valid) |-> (fill_count != '0));

endmodule

`default_nettype wire
